/* hdl/l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache
#(
	parameter int IDX_BITS = 3
)
(
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire l2_pkg::arb_req_t        arb_req,
	output logic                         arb_resp,
	output l2_pkg::line_t                arb_rdata,
	output l2_pkg::mem_req_t             mem_req,
	input  wire                          mem_resp,
	input  wire l2_pkg::line_t           mem_rdata,
	input  wire                          psel,
	input  wire                          penable,
	input  wire                          pwrite,
	input  wire [l2_pkg::ADDR_BITS-1:0]  paddr,
	input  wire [31:0]                   pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr
);

	logic                         hit;
	logic                         w2_hit;
	logic                         lru;
	logic                         w1_dirty;
	logic                         w2_dirty;
	l2_pkg::way_load_t            load_w1;
	l2_pkg::way_load_t            load_w2;
	logic                         load_lru;
	logic                         lru_in;
	logic                         w1_dirty_in;
	logic                         w2_dirty_in;
	logic                         wb_sel;
	logic                         rw_sel;
	logic                         mem_read;
	logic                         mem_write;
	logic [l2_pkg::ADDR_BITS-1:0] mem_addr;
	l2_pkg::line_t                mem_wdata;
	l2_pkg::cache_evt_t           evt;

	// Handshake bits come from the controller, address and data from the datapath
	assign mem_req = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: mem_wdata};

	l2_cache_control u_control (
		.clk         (clk),
		.arst_n      (arst_n),
		.arb_read    (arb_req.read),
		.arb_write   (arb_req.write),
		.arb_resp    (arb_resp),
		.hit         (hit),
		.w2_hit      (w2_hit),
		.lru         (lru),
		.w1_dirty    (w1_dirty),
		.w2_dirty    (w2_dirty),
		.load_w1     (load_w1),
		.load_w2     (load_w2),
		.load_lru    (load_lru),
		.lru_in      (lru_in),
		.w1_dirty_in (w1_dirty_in),
		.w2_dirty_in (w2_dirty_in),
		.wb_sel      (wb_sel),
		.rw_sel      (rw_sel),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_resp    (mem_resp),
		.evt         (evt)
	);

	l2_cache_datapath #(
		.IDX_BITS (IDX_BITS)
	) u_datapath (
		.clk         (clk),
		.arst_n      (arst_n),
		.arb_req     (arb_req),
		.arb_rdata   (arb_rdata),
		.load_w1     (load_w1),
		.load_w2     (load_w2),
		.load_lru    (load_lru),
		.lru_in      (lru_in),
		.w1_dirty_in (w1_dirty_in),
		.w2_dirty_in (w2_dirty_in),
		.wb_sel      (wb_sel),
		.rw_sel      (rw_sel),
		.hit         (hit),
		.w2_hit      (w2_hit),
		.lru         (lru),
		.w1_dirty    (w1_dirty),
		.w2_dirty    (w2_dirty),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata)
	);

	l2_cache_regs u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.evt     (evt)
	);

endmodule : l2_cache

`default_nettype wire

/* hdl/l2_cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control
(
	input  wire                clk,
	input  wire                arst_n,
	input  wire                arb_read,
	input  wire                arb_write,
	output logic               arb_resp,
	input  wire                hit,
	input  wire                w2_hit,
	input  wire                lru,
	input  wire                w1_dirty,
	input  wire                w2_dirty,
	output l2_pkg::way_load_t  load_w1,
	output l2_pkg::way_load_t  load_w2,
	output logic               load_lru,
	output logic               lru_in,
	output logic               w1_dirty_in,
	output logic               w2_dirty_in,
	output logic               wb_sel,
	output logic               rw_sel,
	output logic               mem_read,
	output logic               mem_write,
	input  wire                mem_resp,
	output l2_pkg::cache_evt_t evt
);

	// A fill writes the whole way entry, a write hit only the data and dirty bit
	localparam l2_pkg::way_load_t LOAD_NONE = '{data: 1'b0, tag: 1'b0, valid: 1'b0, dirty: 1'b0};
	localparam l2_pkg::way_load_t LOAD_FILL = '{data: 1'b1, tag: 1'b1, valid: 1'b1, dirty: 1'b1};
	localparam l2_pkg::way_load_t LOAD_WRITE = '{data: 1'b1, tag: 1'b0, valid: 1'b0, dirty: 1'b1};

	typedef enum logic [1:0] {
		st_idle,
		st_evict,
		st_replace
	} state_t;

	state_t state;
	state_t next_state;
	logic   req_valid;
	logic   victim_dirty;
	logic   fill_now;
	logic   miss_pending;

	assign req_valid = arb_read || arb_write;

	// The victim is always the way that lru points at
	assign victim_dirty = lru ? w2_dirty : w1_dirty;

	// Memory data is written into the victim way on the response that ends a read
	assign fill_now = mem_resp && ((state == st_replace) || ((state == st_evict) && !victim_dirty));

	always_comb
	begin
		load_w1 = LOAD_NONE;
		load_w2 = LOAD_NONE;
		load_lru = 1'b0;
		lru_in = 1'b0;
		w1_dirty_in = 1'b0;
		w2_dirty_in = 1'b0;
		wb_sel = 1'b0;
		rw_sel = 1'b0;
		arb_resp = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;

		case (state)
			st_idle:
			begin
				if (req_valid && hit)
				begin
					arb_resp = 1'b1;
					load_lru = 1'b1;
					// Point lru at the way that was not touched
					lru_in = !w2_hit;
					if (arb_write)
					begin
						rw_sel = 1'b1;
						if (w2_hit)
						begin
							load_w2 = LOAD_WRITE;
							w2_dirty_in = 1'b1;
						end
						else
						begin
							load_w1 = LOAD_WRITE;
							w1_dirty_in = 1'b1;
						end
					end
				end
			end
			st_evict:
			begin
				if (victim_dirty)
				begin
					mem_write = 1'b1;
					wb_sel = 1'b1;
				end
				else
					mem_read = 1'b1;
			end
			st_replace:
				mem_read = 1'b1;
			default: ;
		endcase

		// Dirty inputs stay low here, so a fill leaves the line clean
		if (fill_now)
		begin
			if (lru)
				load_w2 = LOAD_FILL;
			else
				load_w1 = LOAD_FILL;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (req_valid && !hit)
					next_state = st_evict;
			st_evict:
				if (mem_resp)
					next_state = victim_dirty ? st_replace : st_idle;
			st_replace:
				if (mem_resp)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= st_idle;
		else
			state <= next_state;
	end

	// Remembers that the open request missed, so its closing response is no hit
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			miss_pending <= 1'b0;
		else if (evt.miss)
			miss_pending <= 1'b1;
		else if (arb_resp)
			miss_pending <= 1'b0;
	end

	assign evt = '{
		hit: arb_resp && !miss_pending,
		miss: (state == st_idle) && req_valid && !hit,
		writeback: (state == st_evict) && victim_dirty && mem_resp
	};

endmodule : l2_cache_control

`default_nettype wire

/* hdl/l2_cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath
#(
	parameter int IDX_BITS = 3
)
(
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire l2_pkg::arb_req_t            arb_req,
	output l2_pkg::line_t                    arb_rdata,
	input  wire l2_pkg::way_load_t           load_w1,
	input  wire l2_pkg::way_load_t           load_w2,
	input  wire                              load_lru,
	input  wire                              lru_in,
	input  wire                              w1_dirty_in,
	input  wire                              w2_dirty_in,
	input  wire                              wb_sel,
	input  wire                              rw_sel,
	output logic                             hit,
	output logic                             w2_hit,
	output logic                             lru,
	output logic                             w1_dirty,
	output logic                             w2_dirty,
	output logic [l2_pkg::ADDR_BITS-1:0]     mem_addr,
	output l2_pkg::line_t                    mem_wdata,
	input  wire l2_pkg::line_t               mem_rdata
);

	localparam int NUM_SETS = 1 << IDX_BITS;
	localparam int TAG_BITS = l2_pkg::ADDR_BITS - IDX_BITS - l2_pkg::OFFSET_BITS;

	logic [IDX_BITS-1:0] idx;
	logic [TAG_BITS-1:0] req_tag;
	l2_pkg::line_t       fill_line;
	l2_pkg::way_load_t   way_load [2];
	logic [1:0]          way_dirty_in;
	logic [1:0]          way_hit;
	logic [1:0]          way_dirty;
	logic [TAG_BITS-1:0] way_tag [2];
	l2_pkg::line_t       way_line [2];
	logic [NUM_SETS-1:0] lru_bits;

	// Byte offset bits are ignored since every access moves a whole line
	assign idx = arb_req.addr[l2_pkg::OFFSET_BITS +: IDX_BITS];
	assign req_tag = arb_req.addr[l2_pkg::ADDR_BITS-1 -: TAG_BITS];

	assign way_load[0] = load_w1;
	assign way_load[1] = load_w2;
	assign way_dirty_in = {w2_dirty_in, w1_dirty_in};

	// Write hits take the upstream line, fills take the memory line
	assign fill_line = rw_sel ? arb_req.wdata : mem_rdata;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		l2_pkg::line_t       data_mem [NUM_SETS];
		logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
		logic [NUM_SETS-1:0] valid;
		logic [NUM_SETS-1:0] dirty;

		always_ff @(posedge clk)
		begin
			if (way_load[w].data)
				data_mem[idx] <= fill_line;
			if (way_load[w].tag)
				tag_mem[idx] <= req_tag;
		end

		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				valid <= '0;
				dirty <= '0;
			end
			else
			begin
				if (way_load[w].valid)
					valid[idx] <= 1'b1;
				if (way_load[w].dirty)
					dirty[idx] <= way_dirty_in[w];
			end
		end

		assign way_line[w] = data_mem[idx];
		assign way_tag[w] = tag_mem[idx];
		assign way_dirty[w] = dirty[idx];
		// An invalid entry never matches, whatever its stored tag holds
		assign way_hit[w] = valid[idx] && (tag_mem[idx] == req_tag);
	end

	// One bit per set names the way to evict next
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			lru_bits <= '0;
		else if (load_lru)
			lru_bits[idx] <= lru_in;
	end

	assign hit = |way_hit;
	assign w2_hit = way_hit[1];
	assign lru = lru_bits[idx];
	assign w1_dirty = way_dirty[0];
	assign w2_dirty = way_dirty[1];

	assign arb_rdata = way_hit[1] ? way_line[1] : way_line[0];

	// Write-back goes to where the victim line came from, a fill to the request line
	assign mem_wdata = way_line[lru];
	assign mem_addr = wb_sel ? {way_tag[lru], idx, {l2_pkg::OFFSET_BITS{1'b0}}}
	                         : {req_tag, idx, {l2_pkg::OFFSET_BITS{1'b0}}};

endmodule : l2_cache_datapath

`default_nettype wire

/* hdl/l2_cache_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_regs
(
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          psel,
	input  wire                          penable,
	input  wire                          pwrite,
	input  wire [l2_pkg::ADDR_BITS-1:0]  paddr,
	input  wire [31:0]                   pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,
	input  wire l2_pkg::cache_evt_t      evt
);

	logic        apb_access;
	logic        addr_hit;
	logic        clr_counts;
	logic [2:0]  evt_bits;
	logic [31:0] counts [3];

	assign apb_access = psel && penable;

	// Bit 0 of the control register clears the counters and reads back as zero
	assign clr_counts = apb_access && pwrite && (paddr == l2_pkg::REG_CTRL) && pwdata[0];

	// Counter order is hits, misses, write-backs
	assign evt_bits = {evt.writeback, evt.miss, evt.hit};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 3; i++)
				counts[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				// A clear wins over an event in the same cycle
				if (clr_counts)
					counts[i] <= '0;
				else if (evt_bits[i] && (counts[i] != '1))
					counts[i] <= counts[i] + 32'd1;
			end
		end
	end

	always_comb
	begin
		addr_hit = 1'b1;
		prdata = '0;
		case (paddr)
			l2_pkg::REG_CTRL: prdata = '0;
			l2_pkg::REG_HITS: prdata = counts[0];
			l2_pkg::REG_MISSES: prdata = counts[1];
			l2_pkg::REG_WBACKS: prdata = counts[2];
			default: addr_hit = 1'b0;
		endcase
	end

	// No wait states
	assign pready = 1'b1;
	assign pslverr = apb_access && !addr_hit;

endmodule : l2_cache_regs

`default_nettype wire

/* hdl/l2_pkg.sv */
`default_nettype none

package l2_pkg;

	// Byte address width and the number of byte-offset bits in one line
	localparam int ADDR_BITS = 32;
	localparam int OFFSET_BITS = 4;

	// One cache line holds four 32-bit words
	typedef logic [127:0] line_t;

	// Request from the upstream arbiter, held until arb_resp
	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [ADDR_BITS-1:0] addr;
		line_t                wdata;
	} arb_req_t;

	// Request to physical memory, the address is always line aligned
	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [ADDR_BITS-1:0] addr;
		line_t                wdata;
	} mem_req_t;

	// Load enables for the arrays of one way
	typedef struct packed {
		logic data;
		logic tag;
		logic valid;
		logic dirty;
	} way_load_t;

	// Single-cycle event pulses for the statistics counters
	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} cache_evt_t;

	// APB register map
	localparam logic [ADDR_BITS-1:0] REG_CTRL = 32'h0000_0000;
	localparam logic [ADDR_BITS-1:0] REG_HITS = 32'h0000_0004;
	localparam logic [ADDR_BITS-1:0] REG_MISSES = 32'h0000_0008;
	localparam logic [ADDR_BITS-1:0] REG_WBACKS = 32'h0000_000C;

endpackage : l2_pkg

`default_nettype wire

/* src.f */
hdl/l2_pkg.sv
hdl/l2_cache_control.sv
hdl/l2_cache_datapath.sv
hdl/l2_cache_regs.sv
hdl/l2_cache.sv
verif/l2_mem_model.sv
verif/l2_cache_tb.sv

/* verif/l2_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

	localparam int CYCLES_PER_OP = 40;
	localparam int RESET_CYCLES = 8;

	logic               clk = 1'b0;
	logic               arst_n;
	l2_pkg::arb_req_t   arb_req;
	logic               arb_resp;
	l2_pkg::line_t      arb_rdata;
	l2_pkg::mem_req_t   mem_req;
	logic               mem_resp;
	l2_pkg::line_t      mem_rdata;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [31:0]        paddr;
	logic [31:0]        pwdata;
	logic [31:0]        prdata;
	logic               pready;
	logic               pslverr;
	logic [31:0]        write_count;
	logic [31:0]        last_waddr;
	l2_pkg::line_t      last_wdata;

	// Operations as read from the data file
	logic [3:0]    op_q [$];
	logic [31:0]   addr_q [$];
	l2_pkg::line_t data_q [$];
	l2_pkg::line_t exp_q [$];
	logic          ops_loaded = 1'b0;
	int            errors = 0;
	int            checks = 0;

	always #5 clk = ~clk;

	l2_cache #(
		.IDX_BITS (3)
	) u_l2_cache (
		.clk       (clk),
		.arst_n    (arst_n),
		.arb_req   (arb_req),
		.arb_resp  (arb_resp),
		.arb_rdata (arb_rdata),
		.mem_req   (mem_req),
		.mem_resp  (mem_resp),
		.mem_rdata (mem_rdata),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

	l2_mem_model #(
		.SEED (63545)
	) u_mem_model (
		.clk         (clk),
		.arst_n      (arst_n),
		.mem_req     (mem_req),
		.mem_resp    (mem_resp),
		.mem_rdata   (mem_rdata),
		.write_count (write_count),
		.last_waddr  (last_waddr),
		.last_wdata  (last_wdata)
	);

	// Starts and ends 1 ns after a rising edge, outputs are sampled on the falling edge
	task automatic line_access(input logic is_write, input logic [31:0] addr,
		input l2_pkg::line_t wdata, output l2_pkg::line_t rdata);
		logic got_resp;
		got_resp = 1'b0;
		rdata = '0;
		arb_req = '{read: !is_write, write: is_write, addr: addr, wdata: wdata};
		while (!got_resp)
		begin
			@(negedge clk);
			got_resp = arb_resp;
			rdata = arb_rdata;
			@(posedge clk);
			#1;
		end
		arb_req = '0;
	endtask

	task automatic apb_transfer(input logic is_write, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		logic done;
		done = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = is_write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!done)
		begin
			@(negedge clk);
			done = pready;
			rdata = prdata;
			err = pslverr;
			@(posedge clk);
			#1;
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	initial
	begin
		int            fd;
		int            code;
		logic [3:0]    op;
		logic [31:0]   addr;
		l2_pkg::line_t wdata;
		l2_pkg::line_t expected;
		l2_pkg::line_t rdata;
		logic [31:0]   apb_rdata;
		logic          apb_err;
		logic [8*256-1:0] skip_line;

		arst_n = 1'b0;
		arb_req = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;

		fd = $fopen("verif/l2_cache_testdata.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Could not open verif/l2_cache_testdata.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fscanf(fd, "%h %h %h %h\n", op, addr, wdata, expected);
				if (code == 4)
				begin
					op_q.push_back(op);
					addr_q.push_back(addr);
					data_q.push_back(wdata);
					exp_q.push_back(expected);
				end
				// Comment lines fail the scan and are skipped whole
				else if ($fgets(skip_line, fd) == 0)
					break;
			end
			$fclose(fd);
		end
		if (op_q.size() == 0)
		begin
			errors++;
			$display("The test data file holds no operations");
		end
		ops_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;

		for (int i = 0; i < op_q.size(); i++)
		begin
			case (op_q[i])
				4'h1:
				begin
					line_access(1'b0, addr_q[i], '0, rdata);
					checks++;
					if (rdata !== exp_q[i])
					begin
						errors++;
						$display("FAIL arb_rdata op %0d: expected %h got %h", i, exp_q[i], rdata);
					end
				end
				4'h2:
					line_access(1'b1, addr_q[i], data_q[i], rdata);
				4'h3, 4'h4, 4'h5:
				begin
					apb_transfer(op_q[i] == 4'h4, addr_q[i], data_q[i][31:0], apb_rdata, apb_err);
					checks++;
					if (apb_err !== (op_q[i] == 4'h5))
					begin
						errors++;
						$display("FAIL pslverr op %0d: expected %h got %h", i, op_q[i] == 4'h5,
							apb_err);
					end
					if ((op_q[i] == 4'h3) && (apb_rdata !== exp_q[i][31:0]))
					begin
						errors++;
						$display("FAIL prdata op %0d: expected %h got %h", i, exp_q[i][31:0],
							apb_rdata);
					end
				end
				4'h6:
				begin
					checks++;
					if (write_count !== exp_q[i][31:0])
					begin
						errors++;
						$display("FAIL write_count op %0d: expected %h got %h", i, exp_q[i][31:0],
							write_count);
					end
				end
				4'h7:
				begin
					checks++;
					if (last_waddr !== addr_q[i])
					begin
						errors++;
						$display("FAIL last_waddr op %0d: expected %h got %h", i, addr_q[i],
							last_waddr);
					end
					if (last_wdata !== data_q[i])
					begin
						errors++;
						$display("FAIL last_wdata op %0d: expected %h got %h", i, data_q[i],
							last_wdata);
					end
				end
				default:
				begin
					errors++;
					$display("Operation %0d has an unknown opcode %0d", i, op_q[i]);
				end
			endcase
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog sized from the number of operations in the data file
	initial
	begin
		wait (ops_loaded);
		repeat ((op_q.size() + 1) * CYCLES_PER_OP + RESET_CYCLES) @(posedge clk);
		$display("Timeout: the operations did not complete in the allowed cycles");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : l2_cache_tb

`default_nettype wire

/* verif/l2_cache_testdata.txt */
# Columns: opcode address write_data expected (all hex)
# Opcodes: 1 line read  2 line write  3 APB read  4 APB write  5 APB access to an unmapped address
#          6 memory write count  7 last memory write (address and data columns)
# Memory lines start as word i = line address + 4*i so line A holds {A+C A+8 A+4 A}
# Cold read miss in set 4 then a hit on the same line
1 00000040 0 0000004c000000480000004400000040
1 00000040 0 0000004c000000480000004400000040
# Write hit stays in the cache
2 00000040 11111111222222223333333344444444 0
1 00000040 0 11111111222222223333333344444444
6 00000000 0 0
# Set 0 with tags A=000 B=080 C=100 D=180
1 00000000 0 0000000c000000080000000400000000
2 00000080 b0b0b0b0b1b1b1b1b2b2b2b2b3b3b3b3 0
1 00000000 0 0000000c000000080000000400000000
# C evicts dirty B which is the least recently used way
1 00000100 0 0000010c000001080000010400000100
6 00000000 0 1
7 00000080 b0b0b0b0b1b1b1b1b2b2b2b2b3b3b3b3 0
# B comes back from memory and evicts clean A with no write
1 00000080 0 b0b0b0b0b1b1b1b1b2b2b2b2b3b3b3b3
6 00000000 0 1
# C made dirty then D evicts clean B
2 00000100 c0c0c0c0c1c1c1c1c2c2c2c2c3c3c3c3 0
1 00000180 0 0000018c000001880000018400000180
6 00000000 0 1
# A evicts dirty C
1 00000000 0 0000000c000000080000000400000000
6 00000000 0 2
7 00000100 c0c0c0c0c1c1c1c1c2c2c2c2c3c3c3c3 0
# Counters hold 5 hits 7 misses 2 write-backs
3 00000004 0 5
3 00000008 0 7
3 0000000c 0 2
3 00000000 0 0
5 00000010 0 0
# Clear the counters through the control register
4 00000000 1 0
3 00000004 0 0
3 00000008 0 0
3 0000000c 0 0
# One more hit after the clear
1 00000040 0 11111111222222223333333344444444
3 00000004 0 1
3 00000008 0 0
3 0000000c 0 0

/* verif/l2_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model
#(
	parameter int SEED = 1
)
(
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire l2_pkg::mem_req_t mem_req,
	output logic                  mem_resp,
	output l2_pkg::line_t         mem_rdata,
	output logic [31:0]           write_count,
	output logic [31:0]           last_waddr,
	output l2_pkg::line_t         last_wdata
);

	// Only lines that were written are stored, all others follow the fill rule
	l2_pkg::line_t lines [logic [31:0]];

	function automatic l2_pkg::line_t read_line(input logic [31:0] addr);
		if (lines.exists(addr))
			return lines[addr];
		// Word i of an untouched line holds the byte address of that word
		return {addr + 32'hC, addr + 32'h8, addr + 32'h4, addr};
	endfunction

	initial
	begin
		logic [31:0] line_addr;
		void'($urandom(SEED));
		mem_resp = 1'b0;
		mem_rdata = '0;
		write_count = '0;
		last_waddr = '0;
		last_wdata = '0;
		wait (arst_n === 1'b1);
		forever
		begin
			@(posedge clk);
			#1;
			mem_resp = 1'b0;
			if (mem_req.read || mem_req.write)
			begin
				// The controller holds its request, so the response comes one to five cycles later
				repeat ($urandom_range(4, 0))
				begin
					@(posedge clk);
					#1;
				end
				line_addr = {mem_req.addr[31:l2_pkg::OFFSET_BITS], {l2_pkg::OFFSET_BITS{1'b0}}};
				if (mem_req.write)
				begin
					lines[line_addr] = mem_req.wdata;
					write_count = write_count + 32'd1;
					last_waddr = line_addr;
					last_wdata = mem_req.wdata;
				end
				else
					mem_rdata = read_line(line_addr);
				mem_resp = 1'b1;
			end
		end
	end

endmodule : l2_mem_model

`default_nettype wire
